// ==== src/pet_params.svh ====
// Bridge sizing macros, included by any RTL or testbench file that needs FIFO, strobe or command sizes
`ifndef PET_PARAMS_SVH
`define PET_PARAMS_SVH

// Commands that can wait in the queue (power of two, 2 or more)
`define PET_FIFO_DEPTH 4

// RAM OE/WE strobe length in clk16_i cycles
`define PET_STROBE_CYCLES 4

// Bytes per SPI command: control, addr hi, addr lo, data
`define PET_CMD_BYTES 4

`endif

// ==== src/pet_pkg.sv ====
// Shared bridge types, imported by the SPI receiver, bus master, top and testbench
package pet_pkg;

    // Direction encodings, taken from bit 0 of the control byte
    localparam logic PET_RW_READ  = 1'b1;  // Matches bus R/W high level
    localparam logic PET_RW_WRITE = 1'b0;  // Matches bus R/W low level

    // One queued bus access, 25 bits
    typedef struct packed {
        logic        rw;    // 1 = read, 0 = write
        logic [15:0] addr;  // CPU address
        logic [7:0]  data;  // Write data, don't care for reads
    } bus_cmd_t;

endpackage

// ==== src/spi_cmd_rx.sv ====
// SPI mode 0 peripheral that assembles MCU bus commands and returns the last read byte on POCI
`timescale 1ns/1ps
`include "pet_params.svh"

module spi_cmd_rx (
    input  logic              clk16_i,     // 16 MHz system clock
    input  logic              rst_n_i,     // Sync reset, active low
    input  logic              spi1_sck_i,  // SCK from MCU, async
    input  logic              spi1_cs_ni,  // CS from MCU, async, active low
    input  logic              spi1_rx_i,   // PICO
    input  logic [7:0]        rd_data_i,   // Last byte read by bus master
    input  logic              full_i,      // Command FIFO has no room
    output logic              spi1_tx_o,   // POCI
    output logic              push_o,      // One-cycle push into FIFO
    output pet_pkg::bus_cmd_t push_cmd_o   // Completed command
);
    import pet_pkg::*;

    localparam int BYTE_W = (`PET_CMD_BYTES > 1) ? $clog2(`PET_CMD_BYTES) : 1;

    logic [1:0]        sck_sync;     // Two-flop synchronizers
    logic [1:0]        cs_sync;
    logic [1:0]        rx_sync;
    logic              sck_prev;     // Last synced SCK, for edge detect
    logic              cs_prev;      // Last synced CS
    logic              selected;     // CS asserted in clk16_i domain
    logic              sck_rise;     // Sample PICO
    logic              sck_fall;     // Advance POCI
    logic              cs_fall;      // Start of a transfer
    logic [2:0]        bit_cnt;      // Bit within current byte
    logic [BYTE_W-1:0] byte_cnt;     // Byte within current command
    logic [7:0]        rx_shift;     // Incoming byte, MSB first
    logic [7:0]        rx_byte;      // Shift register including bit now sampled
    logic [7:0]        tx_shift;     // Outgoing read-back byte
    bus_cmd_t          cmd_q;        // Command under assembly

    // Bring the SPI pins into the clk16_i domain
    always_ff @(posedge clk16_i) begin
        if (!rst_n_i) begin
            sck_sync <= '0;
            cs_sync  <= '1;          // Deselected
            rx_sync  <= '0;
            sck_prev <= 1'b0;
            cs_prev  <= 1'b1;
        end else begin
            sck_sync <= {sck_sync[0], spi1_sck_i};
            cs_sync  <= {cs_sync[0], spi1_cs_ni};
            rx_sync  <= {rx_sync[0], spi1_rx_i};
            sck_prev <= sck_sync[1];
            cs_prev  <= cs_sync[1];
        end
    end

    assign selected = !cs_sync[1];
    assign sck_rise = selected && sck_sync[1] && !sck_prev;
    assign sck_fall = selected && !sck_sync[1] && sck_prev;
    assign cs_fall  = cs_prev && !cs_sync[1];
    assign rx_byte  = {rx_shift[6:0], rx_sync[1]};

    // Bit/byte counters and push strobe
    always_ff @(posedge clk16_i) begin
        if (!rst_n_i) begin
            bit_cnt  <= '0;
            byte_cnt <= '0;
            push_o   <= 1'b0;
        end else begin
            push_o <= 1'b0;
            if (!selected) begin
                bit_cnt  <= '0;      // CS high drops any partial command
                byte_cnt <= '0;
            end else if (sck_rise) begin
                bit_cnt <= bit_cnt + 3'd1;  // Wraps every 8 bits
                if (bit_cnt == 3'd7) begin
                    if (byte_cnt == BYTE_W'(`PET_CMD_BYTES - 1)) begin
                        byte_cnt <= '0;
                        push_o   <= !full_i;  // Dropped when queue is full
                    end else begin
                        byte_cnt <= byte_cnt + 1'b1;
                    end
                end
            end
        end
    end

    // Shift in PICO and route each finished byte into its field
    always_ff @(posedge clk16_i) begin
        if (sck_rise) begin
            rx_shift <= rx_byte;
            if (bit_cnt == 3'd7) begin
                if (byte_cnt == BYTE_W'(0)) begin
                    cmd_q.rw <= rx_byte[0];          // Control byte
                end else if (byte_cnt == BYTE_W'(1)) begin
                    cmd_q.addr[15:8] <= rx_byte;
                end else if (byte_cnt == BYTE_W'(2)) begin
                    cmd_q.addr[7:0] <= rx_byte;
                end else begin
                    cmd_q.data <= rx_byte;           // Last byte, pushed next cycle
                end
            end
        end
    end

    assign push_cmd_o = cmd_q;

    // Read-back: load on CS fall, MSB leads, zeros after byte 1
    always_ff @(posedge clk16_i) begin
        if (!rst_n_i) begin
            tx_shift <= '0;
        end else if (cs_fall) begin
            tx_shift <= rd_data_i;
        end else if (sck_fall) begin
            tx_shift <= {tx_shift[6:0], 1'b0};  // Next bit ready before next rise
        end
    end

    assign spi1_tx_o = tx_shift[7];

endmodule

// ==== src/cmd_fifo.sv ====
// Synchronous FIFO for any payload type, queues bus commands between SPI receiver and bus master
`timescale 1ns/1ps

module cmd_fifo #(
    parameter type payload_t = logic [7:0],  // Entry type
    parameter int  DEPTH     = 4             // Power of two, 2 or more
) (
    input  logic     clk16_i,      // 16 MHz system clock
    input  logic     rst_n_i,      // Sync reset, active low
    input  logic     push_i,       // Write push_data_i this cycle
    input  payload_t push_data_i,
    input  logic     pop_i,        // Drop head entry this cycle
    output payload_t pop_data_o,   // Head entry, valid while not empty
    output logic     empty_o,
    output logic     full_o
);
    localparam int AW = $clog2(DEPTH);

    payload_t      mem [DEPTH];   // Entry storage
    logic [AW:0]   wr_ptr;        // Extra MSB tells full from empty
    logic [AW:0]   rd_ptr;
    logic          do_push;
    logic          do_pop;

    assign empty_o = (wr_ptr == rd_ptr);
    assign full_o  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    // A pop frees the head slot, so a push can land even when full
    assign do_pop  = pop_i && !empty_o;
    assign do_push = push_i && (!full_o || do_pop);

    always_ff @(posedge clk16_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Storage, no reset needed
    always_ff @(posedge clk16_i) begin
        if (do_push) begin
            mem[wr_ptr[AW-1:0]] <= push_data_i;
        end
    end

    assign pop_data_o = mem[rd_ptr[AW-1:0]];  // Unregistered head

endmodule

// ==== src/bus_master.sv ====
// System bus master that runs each queued command as one timed RAM read or write cycle
`timescale 1ns/1ps
`include "pet_params.svh"

module bus_master (
    input  logic              clk16_i,        // 16 MHz system clock
    input  logic              rst_n_i,        // Sync reset, active low
    input  logic              empty_i,        // No command waiting
    input  pet_pkg::bus_cmd_t pop_cmd_i,      // Head of command FIFO
    input  logic [7:0]        bus_data_i,     // Data bus from RAM
    output logic              pop_o,          // Take head command
    output logic [16:0]       bus_addr_o,     // A16 always low
    output logic              bus_addr_oe_o,
    output logic [7:0]        bus_data_o,
    output logic              bus_data_oe_o,  // Writes only
    output logic              bus_rw_o,       // 1 = read, 0 = write
    output logic              ram_oe_o,       // Active high read strobe
    output logic              ram_we_o,       // Active high write strobe
    output logic [7:0]        rd_data_o,      // Last byte read
    output logic              spi_ready_o     // Queue empty and bus idle
);
    import pet_pkg::*;

    localparam int CNT_W = $clog2(`PET_STROBE_CYCLES + 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_STROBE,
        ST_RELEASE
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] strobe_cnt;   // Strobe cycles still to go, minus one
    logic             is_read;      // Direction of command in flight
    logic [15:0]      addr_q;
    logic [7:0]       data_q;

    assign pop_o = (state == ST_IDLE) && !empty_i;  // Pop cycle precedes ADDR

    // Sequencer and bus controls
    always_ff @(posedge clk16_i) begin
        if (!rst_n_i) begin
            state         <= ST_IDLE;
            strobe_cnt    <= '0;
            is_read       <= 1'b1;
            bus_addr_oe_o <= 1'b0;
            bus_data_oe_o <= 1'b0;
            bus_rw_o      <= 1'b1;      // Park bus in read
            ram_oe_o      <= 1'b0;
            ram_we_o      <= 1'b0;
            rd_data_o     <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (pop_o) begin
                        state         <= ST_ADDR;
                        is_read       <= (pop_cmd_i.rw == PET_RW_READ);
                        bus_addr_oe_o <= 1'b1;
                        bus_rw_o      <= pop_cmd_i.rw;
                        bus_data_oe_o <= (pop_cmd_i.rw == PET_RW_WRITE);  // Drive data on writes
                    end
                end
                ST_ADDR: begin
                    // Address settled for one cycle, now strobe
                    state      <= ST_STROBE;
                    strobe_cnt <= CNT_W'(`PET_STROBE_CYCLES - 1);
                    ram_oe_o   <= is_read;
                    ram_we_o   <= !is_read;
                end
                ST_STROBE: begin
                    if (strobe_cnt == '0) begin
                        state         <= ST_RELEASE;
                        ram_oe_o      <= 1'b0;
                        ram_we_o      <= 1'b0;
                        bus_addr_oe_o <= 1'b0;
                        bus_data_oe_o <= 1'b0;
                        bus_rw_o      <= 1'b1;
                        if (is_read) begin
                            rd_data_o <= bus_data_i;  // Sample at end of OE
                        end
                    end else begin
                        strobe_cnt <= strobe_cnt - 1'b1;
                    end
                end
                default: begin
                    state <= ST_IDLE;  // RELEASE, bus floats one cycle
                end
            endcase
        end
    end

    // Address and data payload, held for the whole access
    always_ff @(posedge clk16_i) begin
        if (pop_o) begin
            addr_q <= pop_cmd_i.addr;
            data_q <= pop_cmd_i.data;
        end
    end

    assign bus_addr_o  = {1'b0, addr_q};  // 6502 bus is 16 bits wide
    assign bus_data_o  = data_q;
    assign spi_ready_o = empty_i && (state == ST_IDLE);

endmodule

// ==== src/pet_bus_top.sv ====
// Pin-level top of the MCU bridge: active-low pin conversion, per-bit output enables and the datapath
`timescale 1ns/1ps
`include "pet_params.svh"

module pet_bus_top (
    input  logic        clk16_i,           // 16 MHz system clock
    input  logic        rst_n_i,           // Sync reset, active low

    // SPI1 from MCU
    input  logic        spi1_sck_i,        // SCK
    input  logic        spi1_cs_ni,        // CS, active low
    input  logic        spi1_mcu_tx_i,     // PICO
    output logic        spi1_mcu_rx_o,     // POCI
    output logic        spi1_mcu_rx_oe,    // Drive POCI only while selected
    output logic        spi_ready_no,      // Low when bridge can take a command

    // System bus
    output logic [15:0] bus_addr_15_0_o,
    output logic [15:0] bus_addr_15_0_oe,
    output logic        bus_addr_16_o,     // Output only
    input  logic [7:0]  bus_data_7_0_i,
    output logic [7:0]  bus_data_7_0_o,
    output logic [7:0]  bus_data_7_0_oe,
    output logic        bus_rw_no,         // 0 = write, 1 = read
    output logic        bus_rw_noe,

    // RAM strobes
    output logic        ram_oe_no,
    output logic        ram_we_no
);
    import pet_pkg::*;

    logic       push;          // Receiver to FIFO
    bus_cmd_t   push_cmd;
    logic       full;
    logic       pop;           // FIFO to bus master
    bus_cmd_t   pop_cmd;
    logic       empty;
    logic [7:0] rd_data;       // Read-back to receiver
    logic       bus_addr_oe;   // Single enables, fanned out per pin
    logic       bus_data_oe;
    logic       ram_oe;        // Active high internally
    logic       ram_we;
    logic       spi_ready;

    assign bus_addr_15_0_oe = {16{bus_addr_oe}};
    assign bus_data_7_0_oe  = {8{bus_data_oe}};
    assign bus_rw_noe       = bus_addr_oe;   // R/W driven with the address

    assign ram_oe_no      = !ram_oe;
    assign ram_we_no      = !ram_we;
    assign spi_ready_no   = !spi_ready;
    assign spi1_mcu_rx_oe = !spi1_cs_ni;

    spi_cmd_rx spi_cmd_rx_i (
        .clk16_i    (clk16_i),
        .rst_n_i    (rst_n_i),
        .spi1_sck_i (spi1_sck_i),
        .spi1_cs_ni (spi1_cs_ni),
        .spi1_rx_i  (spi1_mcu_tx_i),  // PICO in
        .rd_data_i  (rd_data),
        .full_i     (full),
        .spi1_tx_o  (spi1_mcu_rx_o),  // POCI out
        .push_o     (push),
        .push_cmd_o (push_cmd)
    );

    cmd_fifo #(
        .payload_t (bus_cmd_t),
        .DEPTH     (`PET_FIFO_DEPTH)
    ) cmd_fifo_i (
        .clk16_i     (clk16_i),
        .rst_n_i     (rst_n_i),
        .push_i      (push),
        .push_data_i (push_cmd),
        .pop_i       (pop),
        .pop_data_o  (pop_cmd),
        .empty_o     (empty),
        .full_o      (full)
    );

    bus_master bus_master_i (
        .clk16_i       (clk16_i),
        .rst_n_i       (rst_n_i),
        .empty_i       (empty),
        .pop_cmd_i     (pop_cmd),
        .bus_data_i    (bus_data_7_0_i),
        .pop_o         (pop),
        .bus_addr_o    ({bus_addr_16_o, bus_addr_15_0_o}),
        .bus_addr_oe_o (bus_addr_oe),
        .bus_data_o    (bus_data_7_0_o),
        .bus_data_oe_o (bus_data_oe),
        .bus_rw_o      (bus_rw_no),     // Same polarity as the pin
        .ram_oe_o      (ram_oe),
        .ram_we_o      (ram_we),
        .rd_data_o     (rd_data),
        .spi_ready_o   (spi_ready)
    );

endmodule

// ==== sim/tb_clk_gen.sv ====
// Testbench clock and reset source: 10 ns clock, reset held low for a fixed number of cycles
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int RESET_CYCLES = 16   // Rising edges spent in reset
) (
    output logic clk_o,
    output logic rst_n_o
);
    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;    // 100 MHz stand-in for clk16
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);             // Release away from the active edge
        rst_n_o = 1'b1;
    end

endmodule

// ==== sim/pet_bus_chk.sv ====
// Bus strobe assertions, bound into the bridge top for every simulation of it
`timescale 1ns/1ps
`include "pet_params.svh"

module pet_bus_chk (
    input logic       clk16_i,
    input logic       rst_n_i,
    input logic       ram_oe_n_i,     // RAM strobes, active low
    input logic       ram_we_n_i,
    input logic [7:0] bus_data_oe_i,  // Per-bit data enables
    input logic       bus_rw_n_i      // Low on writes
);
    logic [7:0] low_cnt;  // Cycles the current strobe has been low
    logic       strobe_n; // High while neither strobe is active

    assign strobe_n = ram_oe_n_i && ram_we_n_i;

    always_ff @(posedge clk16_i) begin
        if (!rst_n_i) begin
            low_cnt <= '0;
        end else if (!strobe_n) begin
            low_cnt <= low_cnt + 8'd1;
        end else begin
            low_cnt <= '0;  // Restart between pulses
        end
    end

    // Read and write strobes are exclusive
    oe_we_excl: assert property (@(posedge clk16_i) disable iff (!rst_n_i)
        ram_oe_n_i || ram_we_n_i)
        else $error("RAM OE and WE are low in the same cycle");

    data_oe_on_write: assert property (@(posedge clk16_i) disable iff (!rst_n_i)
        (bus_data_oe_i != 8'h00) |-> !bus_rw_n_i)
        else $error("Data bus driven while R/W is high");

    // Counter holds the full pulse length when the strobe returns high
    strobe_len: assert property (@(posedge clk16_i) disable iff (!rst_n_i)
        $rose(strobe_n) |-> (low_cnt == 8'(`PET_STROBE_CYCLES)))
        else $error("RAM strobe pulse has wrong length");

endmodule

bind pet_bus_top pet_bus_chk pet_bus_chk_i (
    .clk16_i       (clk16_i),
    .rst_n_i       (rst_n_i),
    .ram_oe_n_i    (ram_oe_no),
    .ram_we_n_i    (ram_we_no),
    .bus_data_oe_i (bus_data_7_0_oe),
    .bus_rw_n_i    (bus_rw_no)
);

// ==== sim/tb_pet_bus.sv ====
// Bridge testbench: SPI master, RAM model and a table of bus commands run against the pin-level top
`timescale 1ns/1ps
`include "pet_params.svh"

module tb_pet_bus;
    import pet_pkg::*;

    localparam int      SCK_HALF = 5;                    // SCK half-period in clocks
    localparam int      TIMEOUT  = 2000;                 // Clocks allowed per wait
    localparam int      NADDR    = `PET_FIFO_DEPTH + 3;  // Distinct test addresses
    localparam int      CMD_BITS = `PET_CMD_BYTES * 8;
    localparam [1:0]    OP_WRITE = 2'd0;
    localparam [1:0]    OP_READ  = 2'd1;
    localparam [1:0]    OP_ABORT = 2'd2;                 // Write cut off after 2 bytes

    typedef struct packed {
        logic [1:0]  op;
        logic [15:0] addr;
        logic [7:0]  data;
        logic [7:0]  exp_rb;     // Byte expected on POCI during byte 1
        logic        wait_after; // Wait for ready and check RAM writes
    } step_t;

    logic        clk, rst_n, sck, cs_n, pico, poci, poci_oe, ready_n;
    logic [15:0] addr_lo, addr_oe;
    logic        addr_hi, rw_n, rw_noe, ram_oe_n, ram_we_n;
    logic [7:0]  data_in, data_out, data_oe;
    logic [7:0]  ram [65536];             // RAM model
    logic        we_prev = 1'b1;
    logic [23:0] got_wr[$];               // {addr, data} seen by the RAM
    logic [23:0] exp_wr[$];
    step_t       steps[$];
    int          err_cnt = 0;
    int          timeout_cnt = 0;

    tb_clk_gen #(.RESET_CYCLES(16)) tb_clk_gen_i (.clk_o(clk), .rst_n_o(rst_n));

    pet_bus_top pet_bus_top_i (
        .clk16_i (clk), .rst_n_i (rst_n),
        .spi1_sck_i (sck), .spi1_cs_ni (cs_n), .spi1_mcu_tx_i (pico),
        .spi1_mcu_rx_o (poci), .spi1_mcu_rx_oe (poci_oe), .spi_ready_no (ready_n),
        .bus_addr_15_0_o (addr_lo), .bus_addr_15_0_oe (addr_oe), .bus_addr_16_o (addr_hi),
        .bus_data_7_0_i (data_in), .bus_data_7_0_o (data_out), .bus_data_7_0_oe (data_oe),
        .bus_rw_no (rw_n), .bus_rw_noe (rw_noe),
        .ram_oe_no (ram_oe_n), .ram_we_no (ram_we_n)
    );

    assign data_in = ram_oe_n ? 8'hff : ram[addr_lo];  // Idle bus pulled high

    // One logged write per WE pulse, sampled mid-cycle
    always @(negedge clk) begin
        if (!ram_we_n && we_prev) begin
            ram[addr_lo] = data_out;
            got_wr.push_back({addr_lo, data_out});
            $display("RAM write [%h] <= %h", addr_lo, data_out);
        end
        if (!ram_we_n || !ram_oe_n) begin  // Address, R/W and data enables frame every strobe
            check_value("bus_addr_15_0_oe", 32'(addr_oe), 32'hffff);
            check_value("bus_addr_16_o", 32'(addr_hi), 32'h0);
            check_value("bus_rw_noe", 32'(rw_noe), 32'h1);
            check_value("bus_rw_no", 32'(rw_n), 32'(ram_we_n));   // Low only on writes
            check_value("bus_data_7_0_oe", 32'(data_oe), ram_we_n ? 32'h00 : 32'hff);
        end
        we_prev = ram_we_n;
    end

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
            err_cnt++;
        end
    endtask

    // POCI enable is a plain inversion of CS
    always @(posedge clk) begin
        if (rst_n) check_value("spi1_mcu_rx_oe", 32'(poci_oe), 32'(!cs_n));
    end

    // Mode 0 transfer, MSB first; returns the first byte seen on POCI
    task automatic send_command(input logic [31:0] word, input int nbits,
                                output logic [7:0] first_byte);
        logic [7:0] rx;
        int         k;
        rx = '0;
        @(negedge clk);
        cs_n = 1'b0;
        repeat (SCK_HALF) @(negedge clk);    // Lets the read-back byte load
        for (k = 0; k < nbits; k++) begin
            pico = word[31-k];
            repeat (SCK_HALF) @(negedge clk);
            if (k < 8) rx = {rx[6:0], poci};  // Sampled just before SCK rises
            sck = 1'b1;
            repeat (SCK_HALF) @(negedge clk);
            sck = 1'b0;
        end
        repeat (SCK_HALF) @(negedge clk);
        cs_n = 1'b1;
        pico = 1'b0;
        repeat (SCK_HALF) @(negedge clk);
        first_byte = rx;
    endtask

    task automatic wait_ready();
        int n;
        for (n = 0; n < TIMEOUT && ready_n; n++) @(negedge clk);
        if (ready_n) begin
            $display("Timeout: bridge did not signal ready within %0d cycles", TIMEOUT);
            timeout_cnt++;
        end
    endtask

    // RAM writes since the last check must match the commands, in order
    task automatic compare_writes();
        int i;
        if (got_wr.size() != exp_wr.size()) begin
            $display("RAM saw %0d writes where %0d were expected", got_wr.size(), exp_wr.size());
            err_cnt++;
        end else begin
            for (i = 0; i < exp_wr.size(); i++) begin
                check_value("bus_addr_15_0_o", 32'(got_wr[i][23:8]), 32'(exp_wr[i][23:8]));
                check_value("bus_data_7_0_o", 32'(got_wr[i][7:0]), 32'(exp_wr[i][7:0]));
            end
        end
        got_wr.delete();
        exp_wr.delete();
    endtask

    function automatic void add_step(input logic [1:0] op, input logic [15:0] addr,
                                     input logic [7:0] data, input logic [7:0] exp_rb,
                                     input logic wait_after);
        steps.push_back('{op, addr, data, exp_rb, wait_after});
    endfunction

    initial begin
        logic [15:0] a [NADDR];
        logic [7:0]  d [NADDR];
        logic [31:0] rnd;
        logic [7:0]  rb;
        logic        rw;
        int          i, n;
        sck  = 1'b0;
        cs_n = 1'b1;
        pico = 1'b0;
        for (i = 0; i < 65536; i++) ram[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5a;  // Address-wide fill
        rnd = $urandom(32'h6b787a60);
        for (i = 0; i < NADDR; i++) begin
            rnd  = $urandom();
            a[i] = {rnd[15:8], 8'(i)};  // Low byte keeps addresses distinct
            d[i] = rnd[23:16];
        end
        // Read-back reflects the last completed read, zero after reset
        add_step(OP_WRITE, a[0], d[0], 8'h00, 1'b1);
        add_step(OP_READ,  a[0], 8'h00, 8'h00, 1'b1);
        add_step(OP_WRITE, a[1], d[1], d[0], 1'b1);
        for (i = 0; i < `PET_FIFO_DEPTH; i++) begin  // Back-to-back burst
            add_step(OP_WRITE, a[2+i], d[2+i], d[0], 1'(i == `PET_FIFO_DEPTH - 1));
        end
        add_step(OP_ABORT, a[0], ~d[0], d[0], 1'b1);
        add_step(OP_READ,  a[0], 8'h00, d[0], 1'b1);
        add_step(OP_READ,  a[2], 8'h00, d[0], 1'b1);
        add_step(OP_WRITE, a[NADDR-1], d[NADDR-1], d[2], 1'b1);

        for (n = 0; n < 100 && !rst_n; n++) @(negedge clk);
        if (!rst_n) begin
            $display("Timeout: reset was never released");
            timeout_cnt++;
        end
        repeat (2) @(negedge clk);
        check_value("ram_oe_no", 32'(ram_oe_n), 32'h1);
        check_value("ram_we_no", 32'(ram_we_n), 32'h1);
        check_value("bus_rw_no", 32'(rw_n), 32'h1);
        check_value("bus_rw_noe", 32'(rw_noe), 32'h0);
        check_value("bus_addr_15_0_oe", 32'(addr_oe), 32'h0);
        check_value("bus_data_7_0_oe", 32'(data_oe), 32'h0);
        check_value("bus_addr_16_o", 32'(addr_hi), 32'h0);
        check_value("spi_ready_no", 32'(ready_n), 32'h0);

        foreach (steps[s]) begin
            rw = (steps[s].op == OP_READ) ? PET_RW_READ : PET_RW_WRITE;
            send_command({7'b0, rw, steps[s].addr, steps[s].data},
                         (steps[s].op == OP_ABORT) ? 16 : CMD_BITS, rb);
            check_value("spi1_mcu_rx_o", 32'(rb), 32'(steps[s].exp_rb));
            if (steps[s].op == OP_WRITE) exp_wr.push_back({steps[s].addr, steps[s].data});
            if (steps[s].wait_after) begin
                wait_ready();
                compare_writes();
            end
        end

        repeat (10) @(negedge clk);
        $display("Checks done: %0d errors, %0d timeouts", err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+src
src/pet_pkg.sv
src/spi_cmd_rx.sv
src/cmd_fifo.sv
src/bus_master.sv
src/pet_bus_top.sv
sim/tb_clk_gen.sv
sim/pet_bus_chk.sv
sim/tb_pet_bus.sv

// ==== run.sh ====
#!/bin/sh
# Build the bridge testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module tb_pet_bus \
    -Mdir "$BUILD_DIR" -o tb_pet_bus
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/tb_pet_bus" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TB PASSED$" "$LOG"; then
    echo "Simulation result: pass"
    exit 0
fi
echo "Simulation result: fail"
exit 1
